//--- build.f
+incdir+verif
verilog/cache_pkg.sv
verilog/cache_store.sv
verilog/cache_ctrl.sv
verilog/cache_top.sv
verif/tb_cache.sv

//--- run.sh
#!/usr/bin/env bash
# compile and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_cache -f build.f -o sim_cache
if [ $? -ne 0 ]; then
	echo "compile step failed"
	exit 1
fi

output=$(./obj_dir/sim_cache 2>&1)
sim_status=$?
echo "$output"

if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if echo "$output" | grep -q "^STATUS: PASS$"; then
	exit 0
else
	echo "pass message not found in simulation output"
	exit 1
fi

//--- verif/cache_ref_model.svh
// Cache reference model

`ifndef CACHE_REF_MODEL_SVH
`define CACHE_REF_MODEL_SVH

localparam int MODEL_SETS = 4;
localparam int MEM_BLOCKS = 64; // block addresses stay below this

logic         model_valid [2][MODEL_SETS];
logic         model_dirty [2][MODEL_SETS];
logic [25:0]  model_tag   [2][MODEL_SETS];
logic [127:0] model_data  [2][MODEL_SETS];
logic         model_order [MODEL_SETS]; // way filled least recently
logic [127:0] model_mem   [MEM_BLOCKS];

// initial memory word, unique per word address
function automatic logic [31:0] init_word(input int blk, input int off);
	logic [29:0] word_addr;
	word_addr = 30'(blk * 4 + off);
	return {word_addr, 2'b01} ^ 32'h9e37_0000;
endfunction

function automatic logic [127:0] init_block(input int blk);
	logic [127:0] data;
	for (int off = 0; off < 4; off++) begin
		data[off*32 +: 32] = init_word(blk, off);
	end
	return data;
endfunction

task automatic model_reset();
	for (int s = 0; s < MODEL_SETS; s++) begin
		for (int w = 0; w < 2; w++) begin
			model_valid[w][s] = 1'b0;
			model_dirty[w][s] = 1'b0;
			model_tag[w][s]   = '0;
			model_data[w][s]  = '0;
		end
		model_order[s] = 1'b0;
	end
	for (int b = 0; b < MEM_BLOCKS; b++) begin
		model_mem[b] = init_block(b);
	end
endtask

// hit in either way of the set
function automatic logic model_lookup(input logic [29:0] addr, output logic way);
	logic hit;
	hit = 1'b0;
	way = 1'b0;
	for (int w = 0; w < 2; w++) begin
		if (model_valid[w][addr[3:2]] && model_tag[w][addr[3:2]] == addr[29:4]) begin
			hit = 1'b1;
			way = w[0];
		end
	end
	return hit;
endfunction

task automatic model_victim(input logic [29:0] addr, output logic dirty,
		output logic [27:0] blk, output logic [127:0] data);
	logic [1:0] set;
	logic       way;
	set   = addr[3:2];
	way   = model_order[set];
	dirty = model_valid[way][set] && model_dirty[way][set];
	blk   = {model_tag[way][set], set};
	data  = model_data[way][set];
endtask

// write back a dirty victim, then bring in the wanted block
task automatic model_fill(input logic [29:0] addr);
	logic [1:0]  set;
	logic        way;
	logic [27:0] blk;
	set = addr[3:2];
	way = model_order[set];
	blk = {model_tag[way][set], set};
	if (model_valid[way][set] && model_dirty[way][set]) begin
		model_mem[blk[5:0]] = model_data[way][set];
	end
	model_data[way][set]  = model_mem[addr[7:2]];
	model_tag[way][set]   = addr[29:4];
	model_valid[way][set] = 1'b1;
	model_dirty[way][set] = 1'b0;
	model_order[set]      = ~way;
endtask

task automatic model_access(input cache_pkg::proc_req_t req, output logic [31:0] rdata);
	logic way;
	logic hit;
	hit = model_lookup(req.addr, way); // always a hit once filled
	if (req.write) begin
		model_data[way][req.addr[3:2]][req.addr[1:0]*32 +: 32] = req.wdata;
		model_dirty[way][req.addr[3:2]] = 1'b1;
	end
	rdata = model_data[way][req.addr[3:2]][req.addr[1:0]*32 +: 32];
endtask

task automatic check_equal(input string name, input logic [127:0] expected,
		input logic [127:0] actual);
	if (actual !== expected) begin
		$display("ERROR time=%0t signal=%s expected=%0h actual=%0h",
			$time, name, expected, actual);
		$display("STATUS: FAIL");
		$fatal(1, "mismatch on %s", name);
	end
endtask

`endif

//--- verif/tb_cache.sv
// Cache testbench

`timescale 1ns/1ps

module tb_cache;

	localparam int NUM_OPS        = 400;
	localparam int MAX_LAT        = 6;
	localparam int NUM_TAGS       = 5; // small pool, forces evictions
	localparam int TIMEOUT_CYCLES = NUM_OPS * (2 * MAX_LAT + 4) + 100;

	logic                  clk;
	logic                  proc_reset;
	cache_pkg::proc_req_t  proc_req;
	logic [31:0]           proc_rdata;
	logic                  proc_stall;
	logic                  mem_read;
	logic                  mem_write;
	logic [27:0]           mem_addr;
	logic [127:0]          mem_wdata;
	logic [127:0]          mem_rdata;
	logic                  mem_ready;

	integer       seed;
	integer       mem_seed;
	int           lat_left;
	int           cycle_count = 0;
	logic [127:0] backing [64]; // memory behind the cache

	`include "cache_ref_model.svh"

	cache_top uut (
		.clk        (clk),
		.proc_reset (proc_reset),
		.proc_req   (proc_req),
		.proc_rdata (proc_rdata),
		.proc_stall (proc_stall),
		.mem_read   (mem_read),
		.mem_write  (mem_write),
		.mem_addr   (mem_addr),
		.mem_wdata  (mem_wdata),
		.mem_rdata  (mem_rdata),
		.mem_ready  (mem_ready)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("STATUS: FAIL");
			$fatal(1, "timeout");
		end
	end

	// --------------------
	// memory responder, one call per falling edge
	// --------------------
	task automatic serve_memory();
		if (mem_ready) begin
			mem_ready = 1'b0; // single-cycle pulse
			mem_rdata = '0;
		end else if (mem_read || mem_write) begin
			if (lat_left == 0) begin
				lat_left = 1 + ($unsigned($random(mem_seed)) % MAX_LAT);
			end
			lat_left--;
			if (lat_left == 0) begin
				mem_ready = 1'b1;
				if (mem_write) begin
					backing[mem_addr[5:0]] = mem_wdata;
				end else begin
					mem_rdata = backing[mem_addr[5:0]];
				end
			end
		end
	endtask

	initial begin
		cache_pkg::proc_req_t req;
		logic         exp_hit;
		logic         hit_way;
		logic         exp_dirty;
		logic [27:0]  exp_victim_addr;
		logic [127:0] exp_victim_data;
		logic [31:0]  exp_rdata;
		logic         saw_write;
		logic         saw_read;

		seed       = 7;
		mem_seed   = 7;
		lat_left   = 0;
		proc_reset = 1'b1;
		proc_req   = '0;
		mem_rdata  = '0;
		mem_ready  = 1'b0;
		for (int b = 0; b < 64; b++) begin
			backing[b] = init_block(b);
		end
		model_reset();

		repeat (10) @(negedge clk);
		proc_reset = 1'b0;
		#1;
		check_equal("proc_stall", 1, proc_stall); // idle cycle after reset
		check_equal("mem_read", 0, mem_read);
		check_equal("mem_write", 0, mem_write);

		for (int op = 0; op < NUM_OPS; op++) begin
			@(negedge clk);
			serve_memory();
			if (($random(seed) & 7) == 0) begin
				proc_req = '0; // gap between requests
				@(negedge clk);
				serve_memory();
			end
			req.write = $random(seed) & 1;
			req.read  = ~req.write;
			req.addr  = {26'($unsigned($random(seed)) % NUM_TAGS), 4'($random(seed))};
			req.wdata = $random(seed);
			proc_req  = req;

			exp_hit = model_lookup(req.addr, hit_way);
			model_victim(req.addr, exp_dirty, exp_victim_addr, exp_victim_data);
			saw_write = 1'b0;
			saw_read  = 1'b0;
			#1;
			check_equal("proc_stall", !exp_hit, proc_stall);

			// miss in progress
			while (proc_stall) begin
				if (mem_write && !saw_write) begin
					check_equal("mem_write", exp_dirty, 1);
					check_equal("mem_addr", exp_victim_addr, mem_addr);
					check_equal("mem_wdata", exp_victim_data, mem_wdata);
					saw_write = 1'b1;
				end
				if (mem_read && !saw_read) begin
					check_equal("write_back_before_read", exp_dirty, saw_write);
					check_equal("mem_addr", req.addr[29:2], mem_addr);
					saw_read = 1'b1;
				end
				@(negedge clk);
				serve_memory();
				#1;
			end

			if (!exp_hit) begin
				check_equal("mem_read_seen", 1, saw_read);
				model_fill(req.addr);
			end
			model_access(req, exp_rdata);
			if (req.read) begin
				check_equal("proc_rdata", exp_rdata, proc_rdata);
			end
		end

		@(negedge clk);
		proc_req = '0;
		$display("STATUS: PASS");
		$finish;
	end

endmodule

//--- verilog/cache_ctrl.sv
// Cache controller FSM

`timescale 1ns/1ps

module cache_ctrl #(
	parameter int SET_BITS = 2
) (
	input  logic                                 clk,
	input  logic                                 proc_reset,
	input  cache_pkg::proc_req_t                 proc_req,
	input  cache_pkg::store_status_t             status,
	input  logic [cache_pkg::BLOCK_W-1:0]        victim_block,
	input  logic                                 mem_ready,
	output cache_pkg::store_cmd_e                cmd,
	output logic                                 way,
	output logic                                 proc_stall,
	output logic                                 mem_read,
	output logic                                 mem_write,
	output logic [cache_pkg::MEM_ADDR_W-1:0]     mem_addr,
	output logic [cache_pkg::BLOCK_W-1:0]        mem_wdata
);

	localparam int TAG_W = cache_pkg::ADDR_W - cache_pkg::OFFSET_W - SET_BITS;

	cache_pkg::cache_state_e state;
	cache_pkg::cache_state_e state_next;

	logic [TAG_W-1:0]                req_tag;
	logic [SET_BITS-1:0]             req_index;
	logic [cache_pkg::MEM_ADDR_W-1:0] req_block; // block the request wants
	logic                            req_valid;
	logic                            miss;

	assign req_tag   = proc_req.addr[cache_pkg::ADDR_W-1 -: TAG_W];
	assign req_index = proc_req.addr[cache_pkg::OFFSET_W +: SET_BITS];
	assign req_block = {req_tag, req_index};
	assign req_valid = proc_req.read | proc_req.write;
	assign miss      = req_valid & ~status.hit;

	// --------------------
	// state register
	// --------------------
	always_ff @(posedge clk) begin
		if (proc_reset) begin
			state <= cache_pkg::st_idle;
		end else begin
			state <= state_next;
		end
	end

	// --------------------
	// next state, outputs
	// --------------------
	always_comb begin
		state_next = state;
		cmd        = cache_pkg::cmd_none;
		way        = status.victim_way;
		proc_stall = 1'b1;
		mem_read   = 1'b0;
		mem_write  = 1'b0;
		mem_addr   = '0;
		mem_wdata  = '0;

		case (state)
			cache_pkg::st_idle: begin
				state_next = cache_pkg::st_compare; // one stalled cycle after reset
			end

			cache_pkg::st_compare: begin
				proc_stall = miss;
				if (req_valid && status.hit && proc_req.write) begin
					cmd = cache_pkg::cmd_write_word;
					way = status.hit_way;
				end
				if (miss) begin
					// dirty victim goes out before the new block comes in
					state_next = status.victim_dirty ? cache_pkg::st_write_back
					                                 : cache_pkg::st_allocate;
				end
			end

			cache_pkg::st_write_back: begin
				mem_write = 1'b1;
				mem_addr  = status.victim_addr;
				mem_wdata = victim_block;
				if (mem_ready) begin
					cmd        = cache_pkg::cmd_clean;
					state_next = cache_pkg::st_allocate;
				end
			end

			cache_pkg::st_allocate: begin
				mem_read = 1'b1;
				mem_addr = req_block;
				if (mem_ready) begin
					cmd        = cache_pkg::cmd_fill; // lands in the victim way
					state_next = cache_pkg::st_compare;
				end
			end

			default: begin
				state_next = cache_pkg::st_idle;
			end
		endcase
	end

	// --------------------
	// protocol checks
	// --------------------
	a_one_strobe: assert property (
		@(posedge clk) disable iff (proc_reset)
		!(mem_read && mem_write)
	);

	// strobe and address hold until memory answers
	a_strobe_held: assert property (
		@(posedge clk) disable iff (proc_reset)
		(mem_read || mem_write) && !mem_ready |=>
			$stable({mem_read, mem_write, mem_addr})
	);

endmodule

//--- verilog/cache_pkg.sv
// Cache shared types

package cache_pkg;

	// --------------------
	// widths
	// --------------------
	localparam int ADDR_W     = 30;  // processor word address
	localparam int WORD_W     = 32;
	localparam int BLOCK_W    = 128; // four words per block
	localparam int OFFSET_W   = 2;   // word in block
	localparam int MEM_ADDR_W = 28;  // block address on the memory side

	// --------------------
	// enums
	// --------------------

	// controller state
	typedef enum logic [1:0] {
		st_idle,
		st_compare,
		st_write_back,
		st_allocate
	} cache_state_e;

	// line store operation applied at the next clock edge
	typedef enum logic [1:0] {
		cmd_none,
		cmd_write_word, // one word, marks the line dirty
		cmd_fill,       // whole block from memory
		cmd_clean       // victim written back, drop dirty
	} store_cmd_e;

	// --------------------
	// structs
	// --------------------

	// processor request, held while stalled
	typedef struct packed {
		logic              read;
		logic              write;
		logic [ADDR_W-1:0] addr;
		logic [WORD_W-1:0] wdata;
	} proc_req_t;

	// lookup result of the addressed set
	typedef struct packed {
		logic                  hit;
		logic                  hit_way;
		logic                  victim_way;   // way named by the fill-order bit
		logic                  victim_dirty;
		logic [MEM_ADDR_W-1:0] victim_addr;  // victim tag joined with index
	} store_status_t;

endpackage

//--- verilog/cache_store.sv
// Two-way line store

`timescale 1ns/1ps

module cache_store #(
	parameter int SET_BITS = 2
) (
	input  logic                              clk,
	input  logic                              proc_reset,
	input  cache_pkg::proc_req_t              proc_req,
	input  cache_pkg::store_cmd_e             cmd,
	input  logic                              way,
	input  logic [cache_pkg::BLOCK_W-1:0]     fill_block,
	output cache_pkg::store_status_t          status,
	output logic [cache_pkg::WORD_W-1:0]      read_word,
	output logic [cache_pkg::BLOCK_W-1:0]     victim_block
);

	localparam int SETS  = 1 << SET_BITS;
	localparam int TAG_W = cache_pkg::ADDR_W - cache_pkg::OFFSET_W - SET_BITS;

	// one line: valid, dirty, tag, then data
	typedef struct packed {
		logic                          valid;
		logic                          dirty;
		logic [TAG_W-1:0]              tag;
		logic [cache_pkg::BLOCK_W-1:0] data;
	} line_t;

	line_t lines [2][SETS];
	logic [SETS-1:0] fill_order; // way filled least recently, per set

	// --------------------
	// address split
	// --------------------
	logic [TAG_W-1:0]              req_tag;
	logic [SET_BITS-1:0]           req_index;
	logic [cache_pkg::OFFSET_W-1:0] req_offset;

	assign req_tag    = proc_req.addr[cache_pkg::ADDR_W-1 -: TAG_W];
	assign req_index  = proc_req.addr[cache_pkg::OFFSET_W +: SET_BITS];
	assign req_offset = proc_req.addr[cache_pkg::OFFSET_W-1:0];

	// --------------------
	// lookup
	// --------------------
	line_t line0;
	line_t line1;
	line_t hit_line;
	line_t victim_line;
	logic  hit0;
	logic  hit1;
	logic  victim_way;

	assign line0 = lines[0][req_index];
	assign line1 = lines[1][req_index];

	assign hit0 = line0.valid && (line0.tag == req_tag);
	assign hit1 = line1.valid && (line1.tag == req_tag);

	assign victim_way  = fill_order[req_index];
	assign victim_line = victim_way ? line1 : line0;
	assign hit_line    = hit1 ? line1 : line0; // way 0 when nothing hits

	always_comb begin
		status.hit          = hit0 | hit1;
		status.hit_way      = hit1;
		status.victim_way   = victim_way;
		status.victim_dirty = victim_line.valid & victim_line.dirty;
		status.victim_addr  = {victim_line.tag, req_index};
	end

	assign read_word    = hit_line.data[req_offset*cache_pkg::WORD_W +: cache_pkg::WORD_W];
	assign victim_block = victim_line.data;

	// --------------------
	// update
	// --------------------
	always_ff @(posedge clk) begin
		if (proc_reset) begin
			for (int w = 0; w < 2; w++) begin
				for (int s = 0; s < SETS; s++) begin
					lines[w][s] <= '0;
				end
			end
			fill_order <= '0;
		end else begin
			case (cmd)
				cache_pkg::cmd_write_word: begin
					lines[way][req_index].data[req_offset*cache_pkg::WORD_W +: cache_pkg::WORD_W]
						<= proc_req.wdata;
					lines[way][req_index].dirty <= 1'b1;
				end
				cache_pkg::cmd_fill: begin
					lines[way][req_index].data  <= fill_block;
					lines[way][req_index].tag   <= req_tag;
					lines[way][req_index].valid <= 1'b1;
					lines[way][req_index].dirty <= 1'b0;
					fill_order[req_index]       <= ~way; // other way goes next
				end
				cache_pkg::cmd_clean: begin
					lines[way][req_index].dirty <= 1'b0;
				end
				default: begin
				end
			endcase
		end
	end

	// a fill only ever lands on a set that missed in both ways, so a tag
	// can never be present twice in one set
	a_single_way_hit: assert property (
		@(posedge clk) disable iff (proc_reset)
		(proc_req.read || proc_req.write) |-> !(hit0 && hit1)
	);

endmodule

//--- verilog/cache_top.sv
// Two-way write-back cache

`timescale 1ns/1ps

module cache_top (
	input  logic                                 clk,
	input  logic                                 proc_reset,
	// processor side
	input  cache_pkg::proc_req_t                 proc_req,
	output logic [cache_pkg::WORD_W-1:0]         proc_rdata,
	output logic                                 proc_stall,
	// memory side
	output logic                                 mem_read,
	output logic                                 mem_write,
	output logic [cache_pkg::MEM_ADDR_W-1:0]     mem_addr,
	output logic [cache_pkg::BLOCK_W-1:0]        mem_wdata,
	input  logic [cache_pkg::BLOCK_W-1:0]        mem_rdata,
	input  logic                                 mem_ready
);

	localparam int SET_BITS = 2; // 4 sets

	// --------------------
	// store <-> controller
	// --------------------
	cache_pkg::store_cmd_e           cmd;
	logic                            way;
	cache_pkg::store_status_t        status;
	logic [cache_pkg::WORD_W-1:0]    read_word;
	logic [cache_pkg::BLOCK_W-1:0]   victim_block;

	cache_store #(
		.SET_BITS     (SET_BITS)
	) u_store (
		.clk          (clk),
		.proc_reset   (proc_reset),
		.proc_req     (proc_req),
		.cmd          (cmd),
		.way          (way),
		.fill_block   (mem_rdata),   // fill straight from memory
		.status       (status),
		.read_word    (read_word),
		.victim_block (victim_block)
	);

	cache_ctrl #(
		.SET_BITS     (SET_BITS)
	) u_ctrl (
		.clk          (clk),
		.proc_reset   (proc_reset),
		.proc_req     (proc_req),
		.status       (status),
		.victim_block (victim_block),
		.mem_ready    (mem_ready),
		.cmd          (cmd),
		.way          (way),
		.proc_stall   (proc_stall),
		.mem_read     (mem_read),
		.mem_write    (mem_write),
		.mem_addr     (mem_addr),
		.mem_wdata    (mem_wdata)
	);

	assign proc_rdata = read_word; // valid when stall is low

endmodule
